// File: design/tmip_img_pkg.sv
package tmip_img_pkg;

    // 4x4 frame, one byte per pixel
    localparam int IMG_DIM    = 4;
    localparam int IMG_PIXELS = IMG_DIM * IMG_DIM;
    localparam int PIX_W      = 8;

    typedef logic [PIX_W-1:0]               pixel_t;
    typedef logic [$clog2(IMG_DIM)-1:0]     coord_t;
    typedef logic [2*$clog2(IMG_DIM)-1:0]   pix_addr_t;

    // first action entry picks one of these
    typedef enum logic [1:0] {
        GRAY_MAX = 2'd0,
        GRAY_AVG = 2'd1,
        GRAY_WGT = 2'd2
    } gray_sel_t;

    localparam pixel_t PAD_VALUE = 8'd0;

endpackage

// File: design/tmip_op_pkg.sv
package tmip_op_pkg;

    typedef logic [2:0] action_t;

    // op codes inside the action list
    localparam action_t ACT_NEGATE = 3'd4;
    localparam action_t ACT_FLIP   = 3'd5;
    localparam action_t ACT_CONV   = 3'd7;

    // 3x3 template
    localparam int TPL_TAPS = 9;

    // 9 * 255 * 255 fits in 20 bits
    localparam int SUM_W = 20;

    typedef logic [SUM_W-1:0] sum_t;

endpackage

// File: design/tmip_if.sv
`timescale 1ns/1ps

// gray values of one pixel, written into the store on wr
interface gray_px_if
    import tmip_img_pkg::*;
();
    logic      wr;
    pix_addr_t addr;
    pixel_t    g_max;
    pixel_t    g_avg;
    pixel_t    g_wgt;

    modport src (output wr, addr, g_max, g_avg, g_wgt);
    modport dst (input  wr, addr, g_max, g_avg, g_wgt);
endinterface

// combinational read port of the frame store
interface frame_rd_if
    import tmip_img_pkg::*;
();
    gray_sel_t plane;
    coord_t    row;
    coord_t    col;
    pixel_t    pixel;

    modport reader (output plane, row, col, input pixel);
    modport store  (input plane, row, col, output pixel);
endinterface

// File: design/gray_convert.sv
`timescale 1ns/1ps

module gray_convert
    import tmip_img_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   in_valid,
    input  pixel_t image,
    gray_px_if.src px
);

    logic [1:0] phase;
    logic [9:0] sum_q;
    pixel_t     max_q;
    pixel_t     wgt_q;
    logic [9:0] sum_nxt;
    pixel_t     max_nxt;
    pixel_t     wgt_nxt;

    // running sum, max and weighted sum over R, G, B
    always_comb begin
        if (phase == 2'd0) begin
            sum_nxt = 10'(image);
            max_nxt = image;
            wgt_nxt = image >> 2;
        end else begin
            sum_nxt = sum_q + 10'(image);
            max_nxt = (image > max_q) ? image : max_q;
            wgt_nxt = wgt_q + ((phase == 2'd1) ? (image >> 1) : (image >> 2));
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase   <= 2'd0;
            px.wr   <= 1'b0;
            px.addr <= '0;
        end else begin
            px.wr <= in_valid && (phase == 2'd2);
            if (!in_valid || phase == 2'd2) begin
                phase <= 2'd0;
            end else begin
                phase <= phase + 2'd1;
            end
            // address moves on once the pixel is written
            if (px.wr) begin
                px.addr <= px.addr + 1'b1;
            end else if (!in_valid) begin
                px.addr <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            sum_q <= sum_nxt;
            max_q <= max_nxt;
            wgt_q <= wgt_nxt;
        end
        if (in_valid && phase == 2'd2) begin
            px.g_max <= max_nxt;
            px.g_avg <= pixel_t'(sum_nxt / 10'd3);
            px.g_wgt <= wgt_nxt;
        end
    end

endmodule

// File: design/frame_store.sv
`timescale 1ns/1ps

module frame_store
    import tmip_img_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    gray_px_if.dst     px,
    frame_rd_if.store  rd
);

    pixel_t                plane_max [IMG_PIXELS];
    pixel_t                plane_avg [IMG_PIXELS];
    pixel_t                plane_wgt [IMG_PIXELS];
    logic [IMG_PIXELS-1:0] loaded;
    pix_addr_t             rd_addr;

    // all three planes written together
    always_ff @(posedge clk) begin
        if (px.wr) begin
            plane_max[px.addr] <= px.g_max;
            plane_avg[px.addr] <= px.g_avg;
            plane_wgt[px.addr] <= px.g_wgt;
        end
    end

    // pixels never written since reset read back as zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            loaded <= '0;
        end else if (px.wr) begin
            loaded[px.addr] <= 1'b1;
        end
    end

    assign rd_addr = {rd.row, rd.col};

    always_comb begin
        case (rd.plane)
            GRAY_MAX: rd.pixel = plane_max[rd_addr];
            GRAY_AVG: rd.pixel = plane_avg[rd_addr];
            GRAY_WGT: rd.pixel = plane_wgt[rd_addr];
            default:  rd.pixel = '0;
        endcase
        if (!loaded[rd_addr]) begin
            rd.pixel = '0;
        end
    end

endmodule

// File: design/action_decode.sv
`timescale 1ns/1ps

module action_decode
    import tmip_img_pkg::*;
    import tmip_op_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      in_valid2,
    input  action_t   action,
    output gray_sel_t gray_sel,
    output logic      negate,
    output logic      flip,
    output logic      conv_start
);

    // position inside the action burst, at most 8 entries
    logic [2:0] entry;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            entry      <= '0;
            gray_sel   <= GRAY_MAX;
            negate     <= 1'b0;
            flip       <= 1'b0;
            conv_start <= 1'b0;
        end else begin
            conv_start <= 1'b0;
            if (!in_valid2) begin
                entry <= '0;
            end else begin
                entry <= entry + 3'd1;
                if (entry == 3'd0) begin
                    // plane select, flags start clear for this job
                    gray_sel <= gray_sel_t'(action[1:0]);
                    negate   <= 1'b0;
                    flip     <= 1'b0;
                end else begin
                    case (action)
                        ACT_NEGATE: negate     <= ~negate;
                        ACT_FLIP:   flip       <= ~flip;
                        ACT_CONV:   conv_start <= 1'b1;
                        // pooling and median codes have no effect
                        default: ;
                    endcase
                end
            end
        end
    end

endmodule

// File: design/conv_engine.sv
`timescale 1ns/1ps

module conv_engine
    import tmip_img_pkg::*;
    import tmip_op_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        in_valid,
    input  pixel_t      template,
    input  gray_sel_t   gray_sel,
    input  logic        negate,
    input  logic        flip,
    input  logic        conv_start,
    frame_rd_if.reader  rd,
    output logic        res_req,
    output sum_t        res_sum,
    input  logic        res_ack
);

    pixel_t     tpl [TPL_TAPS];
    logic [3:0] tpl_cnt;
    logic       running;
    pix_addr_t  win;
    logic [1:0] tr;
    logic [1:0] tc;
    logic [3:0] k;
    logic       last_tap;
    logic       stall;
    logic [2:0] r_ext;
    logic [2:0] c_ext;
    logic       pad;
    pixel_t     tap_raw;
    pixel_t     tap_val;
    sum_t       acc;
    sum_t       mac_sum;

    // ======================================================================
    // template capture
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tpl_cnt <= '0;
        end else if (!in_valid) begin
            tpl_cnt <= '0;
        end else if (tpl_cnt < TPL_TAPS) begin
            tpl_cnt <= tpl_cnt + 4'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && tpl_cnt < TPL_TAPS) begin
            tpl[tpl_cnt] <= template;
        end
    end

    // ======================================================================
    // window walk and tap fetch
    // ======================================================================
    // window centre is {row, col} of win, tap offset is -1..+1
    assign r_ext = {1'b0, win[3:2]} + {1'b0, tr} - 3'd1;
    assign c_ext = {1'b0, win[1:0]} + {1'b0, tc} - 3'd1;
    assign pad   = (r_ext >= IMG_DIM) || (c_ext >= IMG_DIM);

    assign rd.plane = gray_sel;
    assign rd.row   = coord_t'(r_ext);
    assign rd.col   = flip ? coord_t'(IMG_DIM - 1) - coord_t'(c_ext) : coord_t'(c_ext);

    // padding is inverted along with the pixels
    assign tap_raw = pad ? PAD_VALUE : rd.pixel;
    assign tap_val = negate ? ~tap_raw : tap_raw;

    assign k        = {2'b00, tr} * 4'd3 + {2'b00, tc};
    assign last_tap = (tr == 2'd2) && (tc == 2'd2);
    assign mac_sum  = ((tr == 2'd0 && tc == 2'd0) ? '0 : acc)
                    + sum_t'(tap_val) * sum_t'(tpl[k]);

    // hold the finished window until the previous handshake is over
    assign stall = last_tap && (res_req || res_ack);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            running <= 1'b0;
            win     <= '0;
            tr      <= '0;
            tc      <= '0;
            res_req <= 1'b0;
        end else begin
            if (res_req && res_ack) begin
                res_req <= 1'b0;
            end
            if (conv_start) begin
                running <= 1'b1;
                win     <= '0;
                tr      <= '0;
                tc      <= '0;
            end else if (running && !stall) begin
                if (last_tap) begin
                    res_req <= 1'b1;
                    tr      <= '0;
                    tc      <= '0;
                    win     <= win + 1'b1;
                    if (win == pix_addr_t'(IMG_PIXELS - 1)) begin
                        running <= 1'b0;
                    end
                end else if (tc == 2'd2) begin
                    tc <= '0;
                    tr <= tr + 2'd1;
                end else begin
                    tc <= tc + 2'd1;
                end
            end
        end
    end

    // accumulator, and the hand-off word on the 9th tap
    always_ff @(posedge clk) begin
        if (running && !stall) begin
            if (last_tap) begin
                res_sum <= mac_sum;
            end else begin
                acc <= mac_sum;
            end
        end
    end

endmodule

// File: design/result_serializer.sv
`timescale 1ns/1ps

module result_serializer
    import tmip_op_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic res_req,
    input  sum_t res_sum,
    output logic res_ack,
    output logic out_valid,
    output logic out_value
);

    sum_t       shreg;
    logic [4:0] bit_cnt;
    logic       accept;

    // idle, previous ack gone, new word offered
    assign accept = res_req && !res_ack && !out_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_ack   <= 1'b0;
            out_valid <= 1'b0;
            bit_cnt   <= '0;
        end else begin
            if (accept) begin
                res_ack <= 1'b1;
            end else if (res_ack && !res_req) begin
                res_ack <= 1'b0;
            end

            if (accept) begin
                out_valid <= 1'b1;
                bit_cnt   <= '0;
            end else if (out_valid) begin
                bit_cnt <= bit_cnt + 5'd1;
                if (bit_cnt == 5'(SUM_W - 1)) begin
                    out_valid <= 1'b0;
                end
            end
        end
    end

    // MSB first
    always_ff @(posedge clk) begin
        if (accept) begin
            shreg <= res_sum;
        end else if (out_valid) begin
            shreg <= shreg << 1;
        end
    end

    assign out_value = out_valid & shreg[SUM_W-1];

endmodule

// File: design/tmip_top.sv
`timescale 1ns/1ps

module tmip_top
    import tmip_img_pkg::*;
    import tmip_op_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    in_valid,
    input  logic    in_valid2,
    input  pixel_t  image,
    input  pixel_t  template,
    input  action_t action,
    output logic    out_valid,
    output logic    out_value
);

    gray_sel_t gray_sel;
    logic      negate;
    logic      flip;
    logic      conv_start;
    logic      res_req;
    logic      res_ack;
    sum_t      res_sum;

    gray_px_if  px_bus ();
    frame_rd_if rd_bus ();

    // ======================================================================
    // image load path
    // ======================================================================
    gray_convert u_gray_convert (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .image    (image),
        .px       (px_bus.src)
    );

    frame_store u_frame_store (
        .clk   (clk),
        .rst_n (rst_n),
        .px    (px_bus.dst),
        .rd    (rd_bus.store)
    );

    // ======================================================================
    // actions, convolution, output
    // ======================================================================
    action_decode u_action_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid2  (in_valid2),
        .action     (action),
        .gray_sel   (gray_sel),
        .negate     (negate),
        .flip       (flip),
        .conv_start (conv_start)
    );

    conv_engine u_conv_engine (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .template   (template),
        .gray_sel   (gray_sel),
        .negate     (negate),
        .flip       (flip),
        .conv_start (conv_start),
        .rd         (rd_bus.reader),
        .res_req    (res_req),
        .res_sum    (res_sum),
        .res_ack    (res_ack)
    );

    result_serializer u_result_serializer (
        .clk       (clk),
        .rst_n     (rst_n),
        .res_req   (res_req),
        .res_sum   (res_sum),
        .res_ack   (res_ack),
        .out_valid (out_valid),
        .out_value (out_value)
    );

endmodule

// File: tests/tmip_assertions.sv
`timescale 1ns/1ps

module tmip_assertions (
    input logic clk,
    input logic rst_n,
    input logic in_valid,
    input logic in_valid2,
    input logic res_req,
    input logic res_ack,
    input logic out_valid,
    input logic out_value
);

    // failures so far, read by the testbench at the end of the run
    int unsigned fail_cnt = 0;

    // ======================================================================
    // four-phase handshake between conv engine and serializer
    // ======================================================================
    ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(res_ack) |-> res_req)
        else begin
            $error("res_ack rose while res_req was low");
            fail_cnt++;
        end

    req_held: assert property (@(posedge clk) disable iff (!rst_n)
        (res_req && !res_ack) |=> res_req)
        else begin
            $error("res_req dropped before res_ack");
            fail_cnt++;
        end

    req_after_ack_low: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(res_req) |-> !res_ack)
        else begin
            $error("res_req rose while res_ack was still high");
            fail_cnt++;
        end

    // output and input protocol
    idle_output_low: assert property (@(posedge clk) disable iff (!rst_n)
        !out_valid |-> !out_value)
        else begin
            $error("out_value high while out_valid low");
            fail_cnt++;
        end

    loads_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(in_valid && in_valid2))
        else begin
            $error("in_valid and in_valid2 high together");
            fail_cnt++;
        end

endmodule

bind tmip_top tmip_assertions u_assertions (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_valid2 (in_valid2),
    .res_req   (res_req),
    .res_ack   (res_ack),
    .out_valid (out_valid),
    .out_value (out_value)
);

// File: tests/tmip_tb.sv
`timescale 1ns/1ps

module tmip_tb
    import tmip_img_pkg::*;
    import tmip_op_pkg::*;
();

    localparam int CLK_PERIOD  = 100;
    localparam int N_CASES     = 6;
    localparam int JOB_BITS    = SUM_W * IMG_PIXELS;
    localparam int TAIL_CYCLES = 40;

    logic    clk;
    logic    rst_n;
    logic    in_valid;
    logic    in_valid2;
    pixel_t  image;
    pixel_t  template;
    action_t action;
    logic    out_valid;
    logic    out_value;

    // op list in octal, first op in the lowest digit, last op is conv
    string case_name  [N_CASES];
    int    case_sel   [N_CASES];
    int    case_ops   [N_CASES];
    int    case_nops  [N_CASES];
    bit    case_fixed [N_CASES];
    int    case_tpl   [N_CASES];
    int    case_sum   [N_CASES];

    int     seed;
    int     img_r [IMG_PIXELS];
    int     img_g [IMG_PIXELS];
    int     img_b [IMG_PIXELS];
    pixel_t stim_bytes [3*IMG_PIXELS];
    int     tpl_m [TPL_TAPS];
    sum_t   exp_word [IMG_PIXELS];
    sum_t   got_word [IMG_PIXELS];
    int     err_count;
    int     pass_count;
    int     fail_count;

    tmip_top u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_valid2 (in_valid2),
        .image     (image),
        .template  (template),
        .action    (action),
        .out_valid (out_valid),
        .out_value (out_value)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    // about 900 cycles per job is ample
    initial begin
        #((N_CASES * 900 + 10) * CLK_PERIOD);
        $display("watchdog expired, the DUT did not finish all jobs in time");
        $display("TEST FAILED");
        $finish;
    end

    function automatic int gray_of(int p, int sel);
        int m;
        case (sel)
            0: begin
                m = (img_r[p] > img_g[p]) ? img_r[p] : img_g[p];
                return (img_b[p] > m) ? img_b[p] : m;
            end
            1: return (img_r[p] + img_g[p] + img_b[p]) / 3;
            default: return img_r[p] / 4 + img_g[p] / 2 + img_b[p] / 4;
        endcase
    endfunction

    task automatic set_case(int idx, string name, int sel, int ops, int nops,
                            bit fixed_img, int tpl_mode, int chk);
        case_name[idx]  = name;
        case_sel[idx]   = sel;
        case_ops[idx]   = ops;
        case_nops[idx]  = nops;
        case_fixed[idx] = fixed_img;
        case_tpl[idx]   = tpl_mode;
        case_sum[idx]   = chk;
    endtask

    // ======================================================================
    // reference model
    // ======================================================================
    task automatic build_model(int idx);
        int p;
        int k;
        int e;
        int w;
        int r;
        int c;
        int v;
        int op;
        int acc;
        bit neg;
        bit flp;
        for (p = 0; p < IMG_PIXELS; p++) begin
            if (case_fixed[idx]) begin
                img_r[p] = 8*p + 3;
                img_g[p] = 8*p + 1;
                img_b[p] = 8*p + 6;
            end else begin
                img_r[p] = $random(seed) & 255;
                img_g[p] = $random(seed) & 255;
                img_b[p] = $random(seed) & 255;
            end
            stim_bytes[3*p]     = pixel_t'(img_r[p]);
            stim_bytes[3*p + 1] = pixel_t'(img_g[p]);
            stim_bytes[3*p + 2] = pixel_t'(img_b[p]);
        end
        // template modes: random, centre tap only, all ones
        for (k = 0; k < TPL_TAPS; k++) begin
            case (case_tpl[idx])
                0: tpl_m[k] = $random(seed) & 255;
                1: tpl_m[k] = (k == 4) ? 1 : 0;
                default: tpl_m[k] = 1;
            endcase
        end
        neg = 1'b0;
        flp = 1'b0;
        for (e = 0; e < case_nops[idx]; e++) begin
            op = (case_ops[idx] >> (3*e)) & 7;
            if (op == ACT_NEGATE) neg = !neg;
            else if (op == ACT_FLIP) flp = !flp;
        end
        for (w = 0; w < IMG_PIXELS; w++) begin
            acc = 0;
            for (k = 0; k < TPL_TAPS; k++) begin
                r = w / IMG_DIM + k / 3 - 1;
                c = w % IMG_DIM + k % 3 - 1;
                if (r < 0 || r >= IMG_DIM || c < 0 || c >= IMG_DIM) begin
                    v = 0;
                end else begin
                    v = gray_of(r*IMG_DIM + (flp ? IMG_DIM - 1 - c : c), case_sel[idx]);
                end
                if (neg) v = 255 - v;
                acc += v * tpl_m[k];
            end
            exp_word[w] = sum_t'(acc);
        end
    endtask

    task automatic load_image();
        int i;
        for (i = 0; i < 3*IMG_PIXELS; i++) begin
            @(posedge clk);
            #1;
            in_valid = 1'b1;
            image    = stim_bytes[i];
            template = (i < TPL_TAPS) ? pixel_t'(tpl_m[i]) : '0;
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        image    = '0;
        template = '0;
    endtask

    task automatic load_actions(int idx);
        int e;
        for (e = 0; e <= case_nops[idx]; e++) begin
            @(posedge clk);
            #1;
            in_valid2 = 1'b1;
            if (e == 0) action = action_t'(case_sel[idx]);
            else action = action_t'((case_ops[idx] >> (3*(e-1))) & 7);
        end
        @(posedge clk);
        #1;
        in_valid2 = 1'b0;
        action    = '0;
    endtask

    // sampled on the falling edge, away from register updates
    task automatic collect_words(output int valid_cycles);
        int   nbits;
        sum_t sh;
        nbits        = 0;
        valid_cycles = 0;
        sh           = '0;
        while (nbits < JOB_BITS) begin
            @(negedge clk);
            if (out_valid) begin
                sh = {sh[SUM_W-2:0], out_value};
                nbits++;
                valid_cycles++;
                if (nbits % SUM_W == 0) got_word[nbits/SUM_W - 1] = sh;
            end
        end
        repeat (TAIL_CYCLES) begin
            @(negedge clk);
            if (out_valid) valid_cycles++;
        end
    endtask

    task automatic run_case(int idx);
        int errs_before;
        int valid_cycles;
        int total;
        int w;
        errs_before = err_count;
        build_model(idx);
        load_image();
        load_actions(idx);
        collect_words(valid_cycles);
        total = 0;
        for (w = 0; w < IMG_PIXELS; w++) begin
            total += int'(got_word[w]);
            if (got_word[w] !== exp_word[w]) begin
                $display("[FAIL] %s word %0d expected %0d actual %0d",
                         case_name[idx], w, exp_word[w], got_word[w]);
                err_count++;
            end
        end
        if (valid_cycles != JOB_BITS) begin
            $display("[FAIL] %s out_valid cycles expected %0d actual %0d",
                     case_name[idx], JOB_BITS, valid_cycles);
            err_count++;
        end
        if (case_sum[idx] >= 0 && total != case_sum[idx]) begin
            $display("[FAIL] %s checksum expected %0d actual %0d",
                     case_name[idx], case_sum[idx], total);
            err_count++;
        end
        if (err_count == errs_before) begin
            pass_count++;
            $display("[DONE] %s passed", case_name[idx]);
        end else begin
            fail_count++;
            $display("[DONE] %s failed with %0d errors", case_name[idx], err_count - errs_before);
        end
    endtask

    initial begin
        int i;
        clk        = 1'b0;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in_valid2  = 1'b0;
        image      = '0;
        template   = '0;
        action     = '0;
        seed       = 24;
        err_count  = 0;
        pass_count = 0;
        fail_count = 0;

        // checksums of the fixed image worked out by hand, -1 means model only
        set_case(0, "max_conv_rand",  0, 'o7,     1, 1'b0, 0, -1);
        set_case(1, "avg_centre",     1, 'o7,     1, 1'b1, 1, 1008);
        set_case(2, "wgt_centre",     2, 'o7,     1, 1'b1, 1, 976);
        set_case(3, "neg_ones",       0, 'o74,    2, 1'b1, 2, 30120);
        set_case(4, "neg_twice_flip", 1, 'o7544,  4, 1'b0, 0, -1);
        set_case(5, "flip_neg_skip",  2, 'o74635, 5, 1'b0, 0, -1);

        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (2) @(posedge clk);

        for (i = 0; i < N_CASES; i++) begin
            run_case(i);
        end

        if (u_dut.u_assertions.fail_cnt != 0) begin
            $display("%0d protocol assertion failures occurred during the run",
                     u_dut.u_assertions.fail_cnt);
        end
        $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
        if (fail_count == 0 && u_dut.u_assertions.fail_cnt == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: tb.f
design/tmip_img_pkg.sv
design/tmip_op_pkg.sv
design/tmip_if.sv
design/gray_convert.sv
design/frame_store.sv
design/action_decode.sv
design/conv_engine.sv
design/result_serializer.sv
design/tmip_top.sv
tests/tmip_assertions.sv
tests/tmip_tb.sv
